/* logic/ild_defines.svh */
`ifndef ILD_DEFINES_SVH
`define ILD_DEFINES_SVH

// ---------------------------------------------------------------------------
// fetch window geometry
// ---------------------------------------------------------------------------

// bytes presented per fetch window
`define ILD_WIN_BYTES 8

// width of one instruction byte
`define ILD_BYTE_W 8

// ---------------------------------------------------------------------------
// carry between windows
// ---------------------------------------------------------------------------

// the longest instruction is 6 bytes, so at most 5 bytes spill over
`define ILD_SPILL_W 3

`endif

/* logic/ild_isa_pkg.sv */
`include "ild_defines.svh"

package ild_isa_pkg;

  // ---------------------------------------------------------------------------
  // instruction set encodings
  // ---------------------------------------------------------------------------

  // the upper nibble of the first byte carries the length code
  typedef logic [3:0] len_code_t;

  // decoded length class of one byte's code
  //   4'ha             -> 6 bytes
  //   4'he             -> 4 bytes
  //   low three bits 0 -> 2 bytes
  //   anything else    -> 3 bytes
  typedef enum logic [1:0] {
    LEN2 = 2'd0,
    LEN3 = 2'd1,
    LEN4 = 2'd2,
    LEN6 = 2'd3
  } len_class_e;

  // the codes that do not follow the low-bit rule
  localparam len_code_t CODE_LEN6 = 4'ha;
  localparam len_code_t CODE_LEN4 = 4'he;

endpackage

/* logic/ild_win_pkg.sv */
`include "ild_defines.svh"

package ild_win_pkg;

  // ---------------------------------------------------------------------------
  // fetch window types
  // ---------------------------------------------------------------------------

  // window data, byte 0 sits in the low bits
  typedef logic [`ILD_WIN_BYTES*`ILD_BYTE_W-1:0] win_bytes_t;

  // one bit per byte position, set where an instruction begins
  typedef logic [`ILD_WIN_BYTES-1:0] start_mask_t;

  // number of starts in a window, 0 up to the full window
  typedef logic [$clog2(`ILD_WIN_BYTES+1)-1:0] start_cnt_t;

  // leading bytes of the next window owned by an earlier instruction
  typedef logic [`ILD_SPILL_W-1:0] spill_t;

endpackage

/* logic/len_class_if.sv */
`timescale 1ns/100ps
`include "ild_defines.svh"

// decoded length classes for one window, valid only in the cycle valid is high
interface len_class_if;

  logic                            valid;
  logic                            flush;
  ild_isa_pkg::len_class_e         len_cls [`ILD_WIN_BYTES];
  logic [`ILD_WIN_BYTES-1:0]       byte_vld;

  modport decode (
    output valid,
    output flush,
    output len_cls,
    output byte_vld
  );

  modport walk (
    input valid,
    input flush,
    input len_cls,
    input byte_vld
  );

endinterface

/* logic/len_class_decode.sv */
`timescale 1ns/100ps
`include "ild_defines.svh"

module len_class_decode (
  input  logic                    win_valid,
  input  logic                    flush,
  input  ild_win_pkg::win_bytes_t win_data,
  len_class_if.decode             cls
);

  // ---------------------------------------------------------------------------
  // per-byte length classification
  // ---------------------------------------------------------------------------

  // every byte is classified, the walk later picks the ones that are starts
  always_comb begin
    ild_isa_pkg::len_code_t code;
    logic [`ILD_BYTE_W-1:0] byte_val;

    code     = '0;
    byte_val = '0;
    for (int i = 0; i < `ILD_WIN_BYTES; i++) begin
      byte_val = win_data[i*`ILD_BYTE_W +: `ILD_BYTE_W];
      code     = byte_val[`ILD_BYTE_W-1 -: 4];

      if (code == ild_isa_pkg::CODE_LEN6) begin
        cls.len_cls[i] = ild_isa_pkg::LEN6;
      end else if (code == ild_isa_pkg::CODE_LEN4) begin
        cls.len_cls[i] = ild_isa_pkg::LEN4;
      end else if (code[2:0] == 3'b000) begin
        cls.len_cls[i] = ild_isa_pkg::LEN2;
      end else begin
        cls.len_cls[i] = ild_isa_pkg::LEN3;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // strobes and byte validity
  // ---------------------------------------------------------------------------

  assign cls.valid = win_valid;
  assign cls.flush = flush;

  // the fetch path always delivers a full window, so all bytes share the strobe
  always_comb begin
    for (int i = 0; i < `ILD_WIN_BYTES; i++) begin
      cls.byte_vld[i] = win_valid;
    end
  end

endmodule

/* logic/boundary_walk.sv */
`timescale 1ns/100ps
`include "ild_defines.svh"

module boundary_walk (
  input  logic                     clk,
  input  logic                     rst_n,
  len_class_if.walk                cls,
  output logic                     walk_valid,
  output ild_win_pkg::start_mask_t walk_mask,
  output ild_win_pkg::spill_t      spill_out
);

  // position cursor, wide enough for the last byte plus the longest length
  localparam int POS_W = $clog2(`ILD_WIN_BYTES + 6);

  ild_win_pkg::spill_t spill_q;
  ild_win_pkg::spill_t eff_spill;
  ild_win_pkg::spill_t next_spill;
  logic [POS_W-1:0]    end_pos;

  function automatic logic [POS_W-1:0] class_len(ild_isa_pkg::len_class_e c);
    logic [POS_W-1:0] len;

    case (c)
      ild_isa_pkg::LEN2: len = POS_W'(2);
      ild_isa_pkg::LEN3: len = POS_W'(3);
      ild_isa_pkg::LEN4: len = POS_W'(4);
      default:           len = POS_W'(6);
    endcase
    return len;
  endfunction

  // a branch target starts clean, so flush drops whatever was carried
  assign eff_spill = cls.flush ? '0 : spill_q;

  // ---------------------------------------------------------------------------
  // boundary chain
  // ---------------------------------------------------------------------------

  // the cursor always holds the next expected start, it jumps by each length
  always_comb begin
    logic [POS_W-1:0] pos;

    pos       = POS_W'(eff_spill);
    walk_mask = '0;
    for (int p = 0; p < `ILD_WIN_BYTES; p++) begin
      if (pos == POS_W'(p) && cls.byte_vld[p]) begin
        walk_mask[p] = 1'b1;
        pos          = POS_W'(p) + class_len(cls.len_cls[p]);
      end
    end
    end_pos = pos;
  end

  // whatever the last instruction reaches past the edge belongs to the next window
  always_comb begin
    if (end_pos > POS_W'(`ILD_WIN_BYTES)) begin
      next_spill = `ILD_SPILL_W'(end_pos - POS_W'(`ILD_WIN_BYTES));
    end else begin
      next_spill = '0;
    end
  end

  // ---------------------------------------------------------------------------
  // spill register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spill_q <= '0;
    end else if (cls.valid) begin
      spill_q <= next_spill;
    end else if (cls.flush) begin
      spill_q <= '0;
    end
  end

  assign walk_valid = cls.valid;
  assign spill_out  = spill_q;

endmodule

/* logic/mark_result.sv */
`timescale 1ns/100ps
`include "ild_defines.svh"

module mark_result (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     walk_valid,
  input  ild_win_pkg::start_mask_t walk_mask,
  output logic                     out_valid,
  output ild_win_pkg::start_mask_t start_mask,
  output ild_win_pkg::start_cnt_t  start_cnt
);

  ild_win_pkg::start_cnt_t mask_cnt;

  // ---------------------------------------------------------------------------
  // start count
  // ---------------------------------------------------------------------------

  always_comb begin
    mask_cnt = '0;
    for (int i = 0; i < `ILD_WIN_BYTES; i++) begin
      mask_cnt = mask_cnt + ild_win_pkg::start_cnt_t'(walk_mask[i]);
    end
  end

  // ---------------------------------------------------------------------------
  // result register
  // ---------------------------------------------------------------------------

  // mask and count hold between windows, only the valid pulse drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_mask <= '0;
      start_cnt  <= '0;
    end else if (walk_valid) begin
      start_mask <= walk_mask;
      start_cnt  <= mask_cnt;
    end
  end

  // one pulse per window, back-to-back windows give back-to-back pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= walk_valid;
    end
  end

endmodule

/* logic/ild_top.sv */
`timescale 1ns/100ps
`include "ild_defines.svh"

module ild_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     win_valid,
  input  ild_win_pkg::win_bytes_t  win_data,
  input  logic                     flush,
  output logic                     out_valid,
  output ild_win_pkg::start_mask_t start_mask,
  output ild_win_pkg::start_cnt_t  start_cnt,
  output ild_win_pkg::spill_t      spill_out
);

  logic                     walk_valid;
  ild_win_pkg::start_mask_t walk_mask;

  // ---------------------------------------------------------------------------
  // decode to walk bundle
  // ---------------------------------------------------------------------------

  len_class_if cls_bus ();

  len_class_decode u_decode (
    .win_valid (win_valid),
    .flush     (flush),
    .win_data  (win_data),
    .cls       (cls_bus.decode)
  );

  // ---------------------------------------------------------------------------
  // boundary walk and result stage
  // ---------------------------------------------------------------------------

  boundary_walk u_walk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cls        (cls_bus.walk),
    .walk_valid (walk_valid),
    .walk_mask  (walk_mask),
    .spill_out  (spill_out)
  );

  mark_result u_result (
    .clk        (clk),
    .rst_n      (rst_n),
    .walk_valid (walk_valid),
    .walk_mask  (walk_mask),
    .out_valid  (out_valid),
    .start_mask (start_mask),
    .start_cnt  (start_cnt)
  );

endmodule

/* tests/ild_tb.sv */
`timescale 1ns/100ps
`include "ild_defines.svh"

module ild_tb;

  typedef struct packed {
    logic        flush;
    logic [63:0] data;
    logic [7:0]  mask;
    logic [3:0]  cnt;
    logic [2:0]  spill;
  } row_t;

  localparam int NUM_ROWS = 10;
  localparam int NUM_RAND = 16;
  // 2 reset cycles, 28 windows, a lone flush and the drain need about 36 cycles
  localparam int MAX_CYCLES = 200;

  // each row expects the spill that the previous rows leave behind
  localparam row_t TABLE [NUM_ROWS] = '{
    '{1'b0, 64'h8181_8181_8181_8181, 8'h55, 4'd4, 3'd0},
    '{1'b0, 64'h0004_0000_3200_0031, 8'h49, 4'd3, 3'd0},
    '{1'b0, 64'h0000_00e5_0000_00e0, 8'h11, 4'd2, 3'd0},
    '{1'b0, 64'h0080_0000_0000_00a0, 8'h41, 4'd2, 3'd0},
    '{1'b0, 64'h0000_a700_8000_0030, 8'h29, 4'd3, 3'd3},
    '{1'b0, 64'h8000_0000_e0aa_aaaa, 8'h88, 4'd2, 3'd1},
    '{1'b0, 64'ha011_1111_1111_a011, 8'h82, 4'd2, 3'd5},
    '{1'b1, 64'h8181_8181_8181_8181, 8'h55, 4'd4, 3'd0},
    '{1'b0, 64'h0040_0000_2000_0010, 8'h49, 4'd3, 3'd1},
    '{1'b0, 64'hf077_0077_7777_e077, 8'ha2, 4'd3, 3'd2}
  };

  logic                     clk;
  logic                     rst_n;
  logic                     win_valid;
  ild_win_pkg::win_bytes_t  win_data;
  logic                     flush;
  logic                     out_valid;
  ild_win_pkg::start_mask_t start_mask;
  ild_win_pkg::start_cnt_t  start_cnt;
  ild_win_pkg::spill_t      spill_out;

  row_t        windows[$];
  logic [31:0] lcg_state = 32'h1bf5_7dc2;
  int          err_cnt   = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          cycle_cnt = 0;

  ild_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_valid  (win_valid),
    .win_data   (win_data),
    .flush      (flush),
    .out_valid  (out_valid),
    .start_mask (start_mask),
    .start_cnt  (start_cnt),
    .spill_out  (spill_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("the run timed out after %0d cycles before all windows were checked",
               cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // helpers and reference model
  // ---------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int code_length(input logic [3:0] code);
    if (code == 4'ha) return 6;
    if (code == 4'he) return 4;
    if (code[2:0] == 3'b000) return 2;
    return 3;
  endfunction

  // a position starts an instruction when it is the spill or where an earlier start ends
  task automatic model_window(input logic fl, input logic [63:0] data,
                              input logic [2:0] spill_in, output logic [7:0] mask,
                              output logic [3:0] cnt, output logic [2:0] spill_nxt);
    int  lens [`ILD_WIN_BYTES];
    int  sp;
    bit  is_start;

    sp        = fl ? 0 : int'(spill_in);
    mask      = '0;
    cnt       = '0;
    spill_nxt = '0;
    for (int p = 0; p < `ILD_WIN_BYTES; p++) begin
      lens[p] = code_length(data[p*8+4 +: 4]);
    end
    for (int p = 0; p < `ILD_WIN_BYTES; p++) begin
      is_start = (p == sp);
      for (int q = 0; q < p; q++) begin
        if (p > sp && mask[q] && q + lens[q] == p) is_start = 1'b1;
      end
      if (is_start) begin
        mask[p] = 1'b1;
        cnt     = cnt + 4'd1;
        if (p + lens[p] > `ILD_WIN_BYTES) spill_nxt = 3'(p + lens[p] - `ILD_WIN_BYTES);
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  task automatic check_window(input string name, input row_t exp_row);
    int errs_before;

    errs_before = err_cnt;
    check_value("out_valid", 64'd1, 64'(out_valid));
    check_value("start_mask", 64'(exp_row.mask), 64'(start_mask));
    check_value("start_cnt", 64'(exp_row.cnt), 64'(start_cnt));
    check_value("spill_out", 64'(exp_row.spill), 64'(spill_out));
    report_test(name, errs_before);
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial begin
    row_t       row;
    logic [2:0] spill_m;
    logic [7:0] m_mask;
    logic [3:0] m_cnt;
    logic [2:0] m_spill;
    int         errs_before;

    rst_n     = 1'b0;
    win_valid = 1'b0;
    win_data  = '0;
    flush     = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    errs_before = err_cnt;
    check_value("out_valid", 64'd0, 64'(out_valid));
    check_value("start_mask", 64'd0, 64'(start_mask));
    check_value("start_cnt", 64'd0, 64'(start_cnt));
    check_value("spill_out", 64'd0, 64'(spill_out));
    report_test("reset state", errs_before);

    foreach (TABLE[i]) windows.push_back(TABLE[i]);
    spill_m = TABLE[NUM_ROWS-1].spill;
    for (int i = 0; i < NUM_RAND; i++) begin
      lcg_state = lcg_next(lcg_state);
      row.data[63:32] = lcg_state;
      lcg_state = lcg_next(lcg_state);
      row.data[31:0] = lcg_state;
      lcg_state = lcg_next(lcg_state);
      row.flush = (lcg_state[30:29] == 2'b00);
      model_window(row.flush, row.data, spill_m, m_mask, m_cnt, m_spill);
      row.mask  = m_mask;
      row.cnt   = m_cnt;
      row.spill = m_spill;
      spill_m   = m_spill;
      windows.push_back(row);
    end

    // one window per cycle, each result is checked while the next one is in decode
    for (int i = 0; i <= windows.size(); i++) begin
      @(posedge clk);
      if (i < windows.size()) begin
        win_valid <= 1'b1;
        win_data  <= windows[i].data;
        flush     <= windows[i].flush;
      end else begin
        win_valid <= 1'b0;
        flush     <= 1'b0;
      end
      @(negedge clk);
      if (i > 0 && i <= NUM_ROWS) check_window($sformatf("table row %0d", i - 1), windows[i-1]);
      if (i > NUM_ROWS) check_window($sformatf("random window %0d", i - 1 - NUM_ROWS),
                                     windows[i-1]);
    end

    @(posedge clk);
    @(negedge clk);
    errs_before = err_cnt;
    check_value("out_valid", 64'd0, 64'(out_valid));
    check_value("start_mask", 64'(windows[windows.size()-1].mask), 64'(start_mask));
    report_test("valid pulse ends and mask holds", errs_before);

    // a window that spills 3 bytes, then a flush on its own, then a clean window
    @(posedge clk);
    win_valid <= 1'b1;
    win_data  <= TABLE[4].data;
    flush     <= 1'b1;
    @(posedge clk);
    win_valid <= 1'b0;
    @(negedge clk);
    errs_before = err_cnt;
    check_value("spill_out", 64'd3, 64'(spill_out));
    @(posedge clk);
    win_valid <= 1'b1;
    win_data  <= TABLE[0].data;
    flush     <= 1'b0;
    @(posedge clk);
    win_valid <= 1'b0;
    @(negedge clk);
    check_value("start_mask", 64'(TABLE[0].mask), 64'(start_mask));
    check_value("spill_out", 64'd0, 64'(spill_out));
    report_test("flush without a window", errs_before);

    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
logic/ild_isa_pkg.sv
logic/ild_win_pkg.sv
logic/len_class_if.sv
logic/len_class_decode.sv
logic/boundary_walk.sv
logic/mark_result.sv
logic/ild_top.sv
tests/ild_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f flist.f --top-module ild_tb -o ild_sim > sim.log 2>&1 &&
  ./obj_dir/ild_sim >> sim.log 2>&1 ||
  { cat sim.log; echo "build or simulation error, see sim.log"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
